// File: aznable_pkg.sv
`default_nettype none

package aznable_pkg;

	// display geometry in pixels per line
	localparam int H_TOTAL = 396;
	localparam int H_ACTIVE = 320;
	localparam int HS_START = 336;
	localparam int HS_END = 368;

	// display geometry in lines per frame
	localparam int V_TOTAL = 256;
	localparam int V_ACTIVE = 240;
	localparam int VS_START = 244;
	localparam int VS_END = 247;

	localparam int CNT_BITS = 9;

	// clk_24 cycles per millisecond
	localparam int MS_PRESCALE = 24000;

	localparam int WKRAM_ADDR_BITS = 14;

	// cpu memory map
	localparam logic [15:0] ADDR_IN0 = 16'h8000;
	localparam logic [15:0] ADDR_PAUSE = 16'h8530;
	localparam logic [15:0] ADDR_MENU = 16'h8531;
	localparam logic [15:0] TIMESTAMP_BASE = 16'h8080;
	localparam logic [15:0] TIMESTAMP_END = 16'h80A0;
	localparam logic [15:0] TIMER_BASE = 16'h80C0;
	localparam logic [15:0] TIMER_END = 16'h80D0;
	localparam logic [15:0] JOY_BASE = 16'h8100;
	localparam logic [15:0] JOY_END = 16'h81C0;
	localparam logic [15:0] WKRAM_BASE = 16'hC000;

	// six devices with 32 buttons each
	localparam int JOY_BITS = 192;
	// seconds count plus change toggle in the top bit
	localparam int TIMESTAMP_BITS = 33;

	// source of the registered cpu read data
	typedef enum logic [2:0] {
		SRC_NONE,
		SRC_IN0,
		SRC_JOY,
		SRC_TIMESTAMP,
		SRC_TIMER,
		SRC_MENU,
		SRC_WKRAM
	} rd_src_t;

endpackage

`default_nettype wire

// File: video_timer.sv
`default_nettype none

module video_timer (
	input wire logic clk_24,
	input wire logic reset,
	input wire logic ce_6,
	output logic [aznable_pkg::CNT_BITS-1:0] hcnt,
	output logic [aznable_pkg::CNT_BITS-1:0] vcnt,
	output logic hblank,
	output logic vblank,
	output logic hsync,
	output logic vsync
);

	logic [aznable_pkg::CNT_BITS-1:0] h_next;
	logic [aznable_pkg::CNT_BITS-1:0] v_next;

	// next counter values, advanced only on a pixel enable
	always_comb
	begin
		h_next = hcnt;
		v_next = vcnt;
		if (ce_6)
		begin
			if (hcnt == aznable_pkg::H_TOTAL - 1)
			begin
				h_next = '0;
				// end of line steps the frame counter
				if (vcnt == aznable_pkg::V_TOTAL - 1)
					v_next = '0;
				else
					v_next = vcnt + 1'b1;
			end
			else
			begin
				h_next = hcnt + 1'b1;
			end
		end
	end

	// flags decode the next values so they change together with the counters
	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			hcnt <= '0;
			vcnt <= '0;
			hblank <= 1'b0;
			vblank <= 1'b0;
			hsync <= 1'b0;
			vsync <= 1'b0;
		end
		else
		begin
			hcnt <= h_next;
			vcnt <= v_next;
			hblank <= (h_next >= aznable_pkg::H_ACTIVE);
			vblank <= (v_next >= aznable_pkg::V_ACTIVE);
			hsync <= (h_next >= aznable_pkg::HS_START) && (h_next < aznable_pkg::HS_END);
			vsync <= (v_next >= aznable_pkg::VS_START) && (v_next < aznable_pkg::VS_END);
		end
	end

	// counters never leave the frame
	a_cnt_range: assert property (
		@(posedge clk_24) disable iff (reset)
		(hcnt < aznable_pkg::H_TOTAL) && (vcnt < aznable_pkg::V_TOTAL)
	);

endmodule

`default_nettype wire

// File: ms_timer.sv
`default_nettype none

module ms_timer (
	input wire logic clk_24,
	input wire logic reset,
	input wire logic timer_clear,
	output logic [15:0] count
);

	logic [$clog2(aznable_pkg::MS_PRESCALE)-1:0] prescale;

	always_ff @(posedge clk_24)
	begin
		if (reset || timer_clear)
		begin
			prescale <= '0;
			count <= '0;
		end
		else if (prescale == aznable_pkg::MS_PRESCALE - 1)
		begin
			// one millisecond elapsed, count wraps at 16 bits
			prescale <= '0;
			count <= count + 1'b1;
		end
		else
		begin
			prescale <= prescale + 1'b1;
		end
	end

	a_prescale_range: assert property (
		@(posedge clk_24) disable iff (reset)
		prescale < aznable_pkg::MS_PRESCALE
	);

endmodule

`default_nettype wire

// File: work_ram.sv
`default_nettype none

module work_ram (
	input wire logic clk_24,
	input wire logic [aznable_pkg::WKRAM_ADDR_BITS-1:0] addr,
	input wire logic wr,
	input wire logic [7:0] wdata,
	output logic [7:0] q
);

	logic [7:0] mem [0:(2**aznable_pkg::WKRAM_ADDR_BITS)-1];

	// read happens before write, so a write cycle returns the old byte
	always_ff @(posedge clk_24)
	begin
		if (wr)
			mem[addr] <= wdata;
		q <= mem[addr];
	end

endmodule

`default_nettype wire

// File: io_map.sv
`default_nettype none

module io_map (
	input wire logic clk_24,
	input wire logic reset,
	input wire logic [15:0] cpu_addr,
	input wire logic cpu_wr,
	input wire logic [7:0] cpu_wdata,
	output logic [7:0] cpu_rdata,
	input wire logic pause,
	input wire logic menu,
	output logic pause_out,
	input wire logic [aznable_pkg::JOY_BITS-1:0] joystick,
	input wire logic [aznable_pkg::TIMESTAMP_BITS-1:0] timestamp,
	input wire logic hsync,
	input wire logic vsync,
	input wire logic hblank,
	input wire logic vblank,
	input wire logic [15:0] timer_count,
	output logic timer_clear,
	output logic ram_wr,
	input wire logic [7:0] ram_q
);

	logic in0_cs;
	logic ts_cs;
	logic timer_cs;
	logic joy_cs;
	logic pause_cs;
	logic menu_cs;
	logic wkram_cs;
	logic pause_trigger;
	logic menu_trigger;
	logic [255:0] joy_ext;
	logic [63:0] ts_ext;
	logic [7:0] in0_byte;
	aznable_pkg::rd_src_t src_d;
	aznable_pkg::rd_src_t src_q;
	logic [7:0] byte_d;
	logic [7:0] byte_q;

	// region decode
	assign in0_cs = (cpu_addr == aznable_pkg::ADDR_IN0);
	assign ts_cs = (cpu_addr >= aznable_pkg::TIMESTAMP_BASE) &&
		(cpu_addr < aznable_pkg::TIMESTAMP_END);
	assign timer_cs = (cpu_addr >= aznable_pkg::TIMER_BASE) && (cpu_addr < aznable_pkg::TIMER_END);
	assign joy_cs = (cpu_addr >= aznable_pkg::JOY_BASE) && (cpu_addr < aznable_pkg::JOY_END);
	assign pause_cs = (cpu_addr == aznable_pkg::ADDR_PAUSE);
	assign menu_cs = (cpu_addr == aznable_pkg::ADDR_MENU);
	assign wkram_cs = (cpu_addr[15:aznable_pkg::WKRAM_ADDR_BITS] ==
		aznable_pkg::WKRAM_BASE[15:aznable_pkg::WKRAM_ADDR_BITS]);

	assign timer_clear = timer_cs && cpu_wr;
	assign ram_wr = wkram_cs && cpu_wr;

	// pause input wins over a trigger write
	always_ff @(posedge clk_24)
	begin
		if (reset || pause)
			pause_trigger <= 1'b0;
		else if (pause_cs && cpu_wr)
			pause_trigger <= 1'b1;
	end

	assign pause_out = pause || pause_trigger;

	// menu input wins over the clearing write
	always_ff @(posedge clk_24)
	begin
		if (reset)
			menu_trigger <= 1'b0;
		else if (menu)
			menu_trigger <= 1'b1;
		else if (menu_cs && cpu_wr)
			menu_trigger <= 1'b0;
	end

	// padded vectors so unused byte slots read zero
	assign joy_ext = {{(256 - aznable_pkg::JOY_BITS){1'b0}}, joystick};
	assign ts_ext = {{(64 - aznable_pkg::TIMESTAMP_BITS){1'b0}}, timestamp};
	// bit 0 is the debug flag, always clear here
	assign in0_byte = {hsync, vsync, hblank, vblank, 2'b10, menu, 1'b0};

	always_comb
	begin
		src_d = aznable_pkg::SRC_NONE;
		byte_d = 8'h00;
		if (in0_cs)
		begin
			src_d = aznable_pkg::SRC_IN0;
			byte_d = in0_byte;
		end
		else if (ts_cs)
		begin
			src_d = aznable_pkg::SRC_TIMESTAMP;
			byte_d = ts_ext[{cpu_addr[2:0], 3'd0} +: 8];
		end
		else if (timer_cs)
		begin
			src_d = aznable_pkg::SRC_TIMER;
			byte_d = timer_count[{cpu_addr[0], 3'd0} +: 8];
		end
		else if (joy_cs)
		begin
			src_d = aznable_pkg::SRC_JOY;
			byte_d = joy_ext[{cpu_addr[4:0], 3'd0} +: 8];
		end
		else if (menu_cs)
		begin
			src_d = aznable_pkg::SRC_MENU;
			byte_d = {8{menu_trigger}};
		end
		else if (wkram_cs)
		begin
			// data comes from the ram output one cycle later
			src_d = aznable_pkg::SRC_WKRAM;
		end
	end

	always_ff @(posedge clk_24)
	begin
		if (reset)
		begin
			src_q <= aznable_pkg::SRC_NONE;
			byte_q <= 8'h00;
		end
		else
		begin
			src_q <= src_d;
			byte_q <= byte_d;
		end
	end

	assign cpu_rdata = (src_q == aznable_pkg::SRC_WKRAM) ? ram_q : byte_q;

	a_one_region: assert property (
		@(posedge clk_24) disable iff (reset)
		$onehot0({in0_cs, ts_cs, timer_cs, joy_cs, pause_cs, menu_cs, wkram_cs})
	);

endmodule

`default_nettype wire

// File: aznable_io.sv
`default_nettype none

module aznable_io (
	input wire logic clk_24,
	input wire logic ce_6,
	input wire logic reset,
	input wire logic pause,
	input wire logic menu,
	input wire logic [aznable_pkg::JOY_BITS-1:0] joystick,
	input wire logic [aznable_pkg::TIMESTAMP_BITS-1:0] timestamp,
	input wire logic [15:0] cpu_addr,
	input wire logic cpu_wr,
	input wire logic [7:0] cpu_wdata,
	output logic [7:0] cpu_rdata,
	output logic pause_out,
	output logic [aznable_pkg::CNT_BITS-1:0] hcnt,
	output logic [aznable_pkg::CNT_BITS-1:0] vcnt,
	output logic hsync,
	output logic vsync,
	output logic hblank,
	output logic vblank
);

	logic [15:0] timer_count;
	logic timer_clear;
	logic ram_wr;
	logic [7:0] ram_q;

	video_timer u_video_timer (
		.clk_24(clk_24),
		.reset(reset),
		.ce_6(ce_6),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.hblank(hblank),
		.vblank(vblank),
		.hsync(hsync),
		.vsync(vsync)
	);

	ms_timer u_ms_timer (
		.clk_24(clk_24),
		.reset(reset),
		.timer_clear(timer_clear),
		.count(timer_count)
	);

	// work ram sees the low address bits directly
	work_ram u_work_ram (
		.clk_24(clk_24),
		.addr(cpu_addr[aznable_pkg::WKRAM_ADDR_BITS-1:0]),
		.wr(ram_wr),
		.wdata(cpu_wdata),
		.q(ram_q)
	);

	io_map u_io_map (
		.clk_24(clk_24),
		.reset(reset),
		.cpu_addr(cpu_addr),
		.cpu_wr(cpu_wr),
		.cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata),
		.pause(pause),
		.menu(menu),
		.pause_out(pause_out),
		.joystick(joystick),
		.timestamp(timestamp),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank),
		.timer_count(timer_count),
		.timer_clear(timer_clear),
		.ram_wr(ram_wr),
		.ram_q(ram_q)
	);

endmodule

`default_nettype wire

// File: tb_aznable_io.sv
`default_nettype none

module tb_aznable_io;

	// a line is 4 * H_TOTAL clocks at one pixel enable in four
	localparam int LINE_WAIT = 4 * aznable_pkg::H_TOTAL + 16;
	// a frame is V_TOTAL lines
	localparam int FRAME_WAIT = 4 * aznable_pkg::H_TOTAL * aznable_pkg::V_TOTAL + 16;
	// about 3.5 ms of clk_24
	localparam int TIMER_WAIT = (aznable_pkg::MS_PRESCALE * 7) / 2;

	logic clk_24 = 1'b0;
	logic ce_6 = 1'b0;
	logic [1:0] ce_phase = 2'd0;
	logic reset;
	logic pause;
	logic menu;
	logic [aznable_pkg::JOY_BITS-1:0] joystick;
	logic [aznable_pkg::TIMESTAMP_BITS-1:0] timestamp;
	logic [15:0] cpu_addr;
	logic cpu_wr;
	logic [7:0] cpu_wdata;
	logic [7:0] cpu_rdata;
	logic pause_out;
	logic [aznable_pkg::CNT_BITS-1:0] hcnt;
	logic [aznable_pkg::CNT_BITS-1:0] vcnt;
	logic hsync;
	logic vsync;
	logic hblank;
	logic vblank;

	integer seed;
	int ce_count = 0;
	logic rd_check;
	logic exp_valid = 1'b0;
	logic [7:0] exp_byte;
	logic [15:0] exp_addr;
	logic [15:0] exp_ms;
	logic menu_model;
	logic [7:0] shadow [0:(2**aznable_pkg::WKRAM_ADDR_BITS)-1];
	logic [15:0] unmapped [8] = '{16'h0000, 16'h1234, 16'h7FFF, 16'h8001,
		16'h80A0, 16'h80D0, 16'hBFFF, aznable_pkg::ADDR_PAUSE};

	aznable_io u_aznable_io (
		.clk_24(clk_24),
		.ce_6(ce_6),
		.reset(reset),
		.pause(pause),
		.menu(menu),
		.joystick(joystick),
		.timestamp(timestamp),
		.cpu_addr(cpu_addr),
		.cpu_wr(cpu_wr),
		.cpu_wdata(cpu_wdata),
		.cpu_rdata(cpu_rdata),
		.pause_out(pause_out),
		.hcnt(hcnt),
		.vcnt(vcnt),
		.hsync(hsync),
		.vsync(vsync),
		.hblank(hblank),
		.vblank(vblank)
	);

	always #4 clk_24 = ~clk_24;

	// pixel enable one clock in four
	always @(negedge clk_24)
	begin
		ce_phase <= ce_phase + 2'd1;
		ce_6 <= (ce_phase == 2'd3);
	end

	// pixel enables since reset, the position the video counters should hold
	always @(posedge clk_24)
	begin
		if (reset)
			ce_count <= 0;
		else if (ce_6)
			ce_count <= ce_count + 1;
	end

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check(input logic [15:0] actual, input logic [15:0] expected,
		input string what);
		if (actual !== expected)
			fail_run($sformatf("ERROR at %0t: %s gave %0h, expected %0h",
				$time, what, actual, expected));
	endtask

	// hsync, vsync, hblank and vblank for a pixel enable count
	function automatic logic [3:0] video_bits(input int count);
		int h;
		int v;
		h = count % aznable_pkg::H_TOTAL;
		v = (count / aznable_pkg::H_TOTAL) % aznable_pkg::V_TOTAL;
		return {(h >= aznable_pkg::HS_START) && (h < aznable_pkg::HS_END),
			(v >= aznable_pkg::VS_START) && (v < aznable_pkg::VS_END),
			h >= aznable_pkg::H_ACTIVE,
			v >= aznable_pkg::V_ACTIVE};
	endfunction

	// expected read byte from the memory map rules
	function automatic logic [7:0] ref_read(input logic [15:0] addr);
		if (addr == aznable_pkg::ADDR_IN0)
			return {video_bits(ce_count), 2'b10, menu, 1'b0};
		if (addr >= aznable_pkg::TIMESTAMP_BASE && addr < aznable_pkg::TIMESTAMP_END)
			// bytes 5 to 7 fall beyond the 33 bits and shift in as zero
			return 8'(timestamp >> (8 * addr[2:0]));
		if (addr >= aznable_pkg::TIMER_BASE && addr < aznable_pkg::TIMER_END)
			return addr[0] ? exp_ms[15:8] : exp_ms[7:0];
		if (addr >= aznable_pkg::JOY_BASE && addr < aznable_pkg::JOY_END)
		begin
			if (addr[4:0] >= 5'd24)
				return 8'h00;
			return 8'(joystick >> (8 * addr[4:0]));
		end
		if (addr == aznable_pkg::ADDR_MENU)
			return menu_model ? 8'hFF : 8'h00;
		if (addr >= aznable_pkg::WKRAM_BASE)
			return shadow[addr[aznable_pkg::WKRAM_ADDR_BITS-1:0]];
		return 8'h00;
	endfunction

	// expectation taken with the address, compared one cycle later
	always @(posedge clk_24)
	begin
		exp_byte <= ref_read(cpu_addr);
		exp_addr <= cpu_addr;
		exp_valid <= rd_check && !reset;
	end

	always @(negedge clk_24)
	begin
		if (exp_valid)
			check({8'h00, cpu_rdata}, {8'h00, exp_byte}, $sformatf("read of %04h", exp_addr));
	end

	// video outputs against the pixel enable count
	always @(negedge clk_24)
	begin
		check(16'(hcnt), 16'(ce_count % aznable_pkg::H_TOTAL), "hcnt");
		check(16'(vcnt),
			16'((ce_count / aznable_pkg::H_TOTAL) % aznable_pkg::V_TOTAL), "vcnt");
		check({12'd0, hsync, vsync, hblank, vblank}, {12'd0, video_bits(ce_count)},
			"sync and blanking");
	end

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_wr = 1'b1;
		rd_check = 1'b0;
		if (addr >= aznable_pkg::WKRAM_BASE)
			shadow[addr[aznable_pkg::WKRAM_ADDR_BITS-1:0]] = data;
		if (addr == aznable_pkg::ADDR_MENU)
			menu_model = 1'b0;
		@(negedge clk_24);
		cpu_wr = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		cpu_addr = addr;
		rd_check = 1'b1;
		@(negedge clk_24);
		rd_check = 1'b0;
	endtask

	// 0 hsync, 1 hblank, 2 vsync, 3 vblank
	function automatic logic video_flag(input int which);
		case (which)
			0: return hsync;
			1: return hblank;
			2: return vsync;
			default: return vblank;
		endcase
	endfunction

	task automatic wait_flag(input int which, input logic level, input int limit,
		input string what);
		int n;
		n = 0;
		while (video_flag(which) !== level)
		begin
			@(negedge clk_24);
			n++;
			if (n > limit)
				fail_run($sformatf("timed out waiting for %s", what));
		end
	endtask

	initial
	begin
		logic [15:0] a;
		logic [15:0] wr_addrs [$];
		int elapsed;
		int c0;
		seed = 29;
		reset = 1'b1;
		pause = 1'b0;
		menu = 1'b0;
		joystick = '0;
		timestamp = '0;
		cpu_addr = 16'h0000;
		cpu_wr = 1'b0;
		cpu_wdata = 8'h00;
		rd_check = 1'b0;
		menu_model = 1'b0;
		exp_ms = 16'h0000;
		repeat (5) @(negedge clk_24);
		reset = 1'b0;
		check({8'h00, cpu_rdata}, 16'h0000, "cpu_rdata after reset");
		check({15'd0, pause_out}, 16'd0, "pause_out after reset");

		// work ram against the shadow copy
		repeat (64)
		begin
			a = aznable_pkg::WKRAM_BASE | (16'($random(seed)) & 16'h3FFF);
			wr_addrs.push_back(a);
			cpu_write(a, 8'($random(seed)));
		end
		foreach (wr_addrs[i])
			cpu_read(wr_addrs[i]);

		// input bytes, zero slots and mirrors
		for (int i = 0; i < 6; i++)
			joystick[i*32 +: 32] = $random(seed);
		timestamp = {1'($random(seed)), 32'($random(seed))};
		for (int k = 0; k < 32; k++)
			cpu_read(aznable_pkg::TIMESTAMP_BASE + 16'(k));
		for (int k = 0; k < 192; k++)
			cpu_read(aznable_pkg::JOY_BASE + 16'(k));
		foreach (unmapped[i])
			cpu_read(unmapped[i]);

		// menu trigger set by the input, cleared by a write
		cpu_read(aznable_pkg::ADDR_MENU);
		menu = 1'b1;
		menu_model = 1'b1;
		@(negedge clk_24);
		menu = 1'b0;
		cpu_read(aznable_pkg::ADDR_MENU);
		cpu_write(aznable_pkg::ADDR_MENU, 8'h00);
		cpu_read(aznable_pkg::ADDR_MENU);
		cpu_addr = aznable_pkg::ADDR_IN0;
		menu = 1'b1;
		menu_model = 1'b1;
		@(negedge clk_24);
		check({12'd0, cpu_rdata[3:0]}, 16'h000A, "IN0 low bits with menu high");
		menu = 1'b0;
		@(negedge clk_24);
		check({12'd0, cpu_rdata[3:0]}, 16'h0008, "IN0 low bits with menu low");

		// pause input and pause trigger
		pause = 1'b1;
		@(negedge clk_24);
		check({15'd0, pause_out}, 16'd1, "pause_out with pause high");
		pause = 1'b0;
		@(negedge clk_24);
		check({15'd0, pause_out}, 16'd0, "pause_out with pause low");
		cpu_write(aznable_pkg::ADDR_PAUSE, 8'h00);
		check({15'd0, pause_out}, 16'd1, "pause_out after trigger write");
		repeat (10) @(negedge clk_24);
		check({15'd0, pause_out}, 16'd1, "pause trigger held");
		pause = 1'b1;
		@(negedge clk_24);
		pause = 1'b0;
		@(negedge clk_24);
		check({15'd0, pause_out}, 16'd0, "pause_out after pause pulse");

		// millisecond count from a clearing write
		cpu_write(aznable_pkg::TIMER_BASE, 8'h00);
		elapsed = 0;
		while (elapsed < TIMER_WAIT)
		begin
			@(negedge clk_24);
			elapsed++;
		end
		exp_ms = 16'(elapsed / aznable_pkg::MS_PRESCALE);
		cpu_read(aznable_pkg::TIMER_BASE);
		exp_ms = 16'((elapsed + 1) / aznable_pkg::MS_PRESCALE);
		cpu_read(aznable_pkg::TIMER_BASE + 16'd1);

		// line length between hsync rises
		wait_flag(0, 1'b0, LINE_WAIT, "hsync low");
		wait_flag(0, 1'b1, LINE_WAIT, "hsync rise");
		c0 = ce_count;
		wait_flag(0, 1'b0, LINE_WAIT, "hsync low");
		wait_flag(0, 1'b1, LINE_WAIT, "next hsync rise");
		check(16'(ce_count - c0), 16'(aznable_pkg::H_TOTAL), "pixel enables per line");

		// horizontal blanking width
		wait_flag(1, 1'b0, LINE_WAIT, "hblank low");
		wait_flag(1, 1'b1, LINE_WAIT, "hblank rise");
		c0 = ce_count;
		wait_flag(1, 1'b0, LINE_WAIT, "hblank fall");
		check(16'(ce_count - c0), 16'(aznable_pkg::H_TOTAL - aznable_pkg::H_ACTIVE),
			"pixel enables in hblank");

		// status byte read every cycle through vertical sync and the frame wrap
		cpu_addr = aznable_pkg::ADDR_IN0;
		rd_check = 1'b1;
		wait_flag(2, 1'b1, FRAME_WAIT, "vsync rise");
		wait_flag(3, 1'b0, FRAME_WAIT, "vblank fall");
		rd_check = 1'b0;

		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: aznable_io.f
aznable_pkg.sv
video_timer.sv
ms_timer.sv
work_ram.sv
io_map.sv
aznable_io.sv
tb_aznable_io.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert -j 0
TOP = tb_aznable_io
FILELIST = aznable_io.f
BUILD_DIR = obj_dir
PASS_MSG = >>> PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(BUILD_DIR)
